//--- hw/osc_pkg.sv
package osc_pkg;

  // Direction of one amplitude step
  // Up adds the step and down subtracts it
  typedef enum logic {
    dir_up   = 1'b0,
    dir_down = 1'b1
  } osc_dir_t;

  // State of the rise/fall machine
  // Rise walks towards the peak and fall walks towards the minimum
  typedef enum logic {
    st_rise = 1'b0,
    st_fall = 1'b1
  } osc_state_t;

endpackage

//--- hw/osc_ramp_if.sv
`timescale 1ns/1ps
`default_nettype none

// Ramp control between the direction FSM and the amplitude register
// The FSM steers, the register only reports where it stands
interface osc_ramp_if #(
  parameter int WAVE_WIDTH_P = 8
) ();

  // One-cycle step strobe
  logic              step;
  // Direction of that step, valid together with step
  osc_pkg::osc_dir_t dir;

  // Amplitude sits at the peak
  logic              at_max;
  // Amplitude sits at the most negative value
  logic              at_min;

  // Steering side
  modport fsm (
    output step,
    output dir,
    input  at_max,
    input  at_min
  );

  // Amplitude side
  modport acc (
    input  step,
    input  dir,
    output at_max,
    output at_min
  );

endinterface

`default_nettype wire

//--- hw/clock_enable.sv
`timescale 1ns/1ps
`default_nettype none

module clock_enable #(
  parameter int COUNTER_WIDTH_P = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Strobe period in system clocks, read every cycle
  input  logic [COUNTER_WIDTH_P-1:0] cr_enable_period,
  // One-cycle enable strobe
  output logic                       enable
);

  //////////////////////////////////////////////////////////////////////
  // Terminal count
  //////////////////////////////////////////////////////////////////////

  logic [COUNTER_WIDTH_P-1:0] counter;
  logic [COUNTER_WIDTH_P-1:0] last_count;
  logic                       wrap;

  // Last count value is period minus one
  // Periods 0 and 1 both mean a strobe on every cycle
  always_comb begin
    if (cr_enable_period > COUNTER_WIDTH_P'(1)) begin
      last_count = cr_enable_period - COUNTER_WIDTH_P'(1);
    end else begin
      last_count = '0;
    end
  end

  // Greater-or-equal so a shrinking period never lets the count run away
  // The counter then wraps on the very next cycle
  assign wrap = (counter >= last_count);

  //////////////////////////////////////////////////////////////////////
  // Counter and strobe register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      counter <= '0;
      enable  <= 1'b0;
    end else begin
      // Strobe follows the wrap compare by one cycle
      enable <= wrap;
      if (wrap) begin
        counter <= '0;
      end else begin
        counter <= counter + COUNTER_WIDTH_P'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/osc_triangle_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module osc_triangle_fsm (
  input  logic   clk,
  input  logic   rst_n,
  // Enable strobe from the period counter
  input  logic   clock_enable,
  // Step and direction out, limit flags in
  osc_ramp_if.fsm ramp
);

  //////////////////////////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////////////////////////

  osc_pkg::osc_state_t state;
  osc_pkg::osc_state_t state_next;
  osc_pkg::osc_dir_t   dir_sel;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Wave starts at the minimum, so the first move is upwards
      state <= osc_pkg::st_rise;
    end else if (clock_enable) begin
      state <= state_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Direction decision
  //////////////////////////////////////////////////////////////////////

  // Turn on the same strobe that finds the limit
  // No enable is spent standing still at a corner
  always_comb begin
    dir_sel    = osc_pkg::dir_up;
    state_next = state;
    case (state)
      osc_pkg::st_rise: begin
        if (ramp.at_max) begin
          // Peak reached, head back down
          dir_sel    = osc_pkg::dir_down;
          state_next = osc_pkg::st_fall;
        end else begin
          dir_sel    = osc_pkg::dir_up;
          state_next = osc_pkg::st_rise;
        end
      end
      osc_pkg::st_fall: begin
        if (ramp.at_min) begin
          // Bottom reached, head back up
          dir_sel    = osc_pkg::dir_up;
          state_next = osc_pkg::st_rise;
        end else begin
          dir_sel    = osc_pkg::dir_down;
          state_next = osc_pkg::st_fall;
        end
      end
      default: begin
        dir_sel    = osc_pkg::dir_up;
        state_next = osc_pkg::st_rise;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Ramp outputs
  //////////////////////////////////////////////////////////////////////

  // Mealy outputs, the strobe passes straight through as the step
  assign ramp.step = clock_enable;
  assign ramp.dir  = dir_sel;

endmodule

`default_nettype wire

//--- hw/osc_amplitude_acc.sv
`timescale 1ns/1ps
`default_nettype none

module osc_amplitude_acc #(
  parameter int                               WAVE_WIDTH_P         = 8,
  // Amount added or removed per step
  parameter int                               WAVE_AMPLITUDE_INC_P = 1,
  // Highest amplitude the wave reaches
  parameter logic signed [WAVE_WIDTH_P-1:0]   WAVE_AMPLITUDE_MAX_P = '0
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // Step and direction in, limit flags out
  osc_ramp_if.acc                         ramp,
  // Current sample
  output logic signed [WAVE_WIDTH_P-1:0]  amplitude
);

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  // Most negative two's complement value
  localparam logic signed [WAVE_WIDTH_P-1:0] AMP_MIN_C =
    {1'b1, {(WAVE_WIDTH_P-1){1'b0}}};

  // Step at sample width
  localparam logic signed [WAVE_WIDTH_P-1:0] AMP_STEP_C =
    WAVE_WIDTH_P'(WAVE_AMPLITUDE_INC_P);

  //////////////////////////////////////////////////////////////////////
  // Amplitude register
  //////////////////////////////////////////////////////////////////////

  logic signed [WAVE_WIDTH_P-1:0] amplitude_up;
  logic signed [WAVE_WIDTH_P-1:0] amplitude_down;

  // Both candidates, direction picks one
  assign amplitude_up   = amplitude + AMP_STEP_C;
  assign amplitude_down = amplitude - AMP_STEP_C;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Triangle begins at its bottom
      amplitude <= AMP_MIN_C;
    end else if (ramp.step) begin
      if (ramp.dir == osc_pkg::dir_up) begin
        amplitude <= amplitude_up;
      end else begin
        amplitude <= amplitude_down;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Limit flags
  //////////////////////////////////////////////////////////////////////

  // Plain equality on the registered value
  // Peak and minimum are exact multiples of the step from the bottom
  assign ramp.at_max = (amplitude == WAVE_AMPLITUDE_MAX_P);
  assign ramp.at_min = (amplitude == AMP_MIN_C);

endmodule

`default_nettype wire

//--- hw/osc_triangle_top.sv
`timescale 1ns/1ps
`default_nettype none

module osc_triangle_top #(
  // System clock frequency in Hz
  parameter int SYS_CLK_FREQUENCY_P = 100_000_000,
  // Output frequency with the enable high on every cycle
  parameter int PRIME_FREQUENCY_P   = 1_000_000,
  // Sample width
  parameter int WAVE_WIDTH_P        = 24,
  // Width of the enable period
  parameter int COUNTER_WIDTH_P     = $clog2(SYS_CLK_FREQUENCY_P)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // Enable period in system clocks, lowers the output frequency
  input  logic [COUNTER_WIDTH_P-1:0]     cr_clock_enable,
  // Signed triangle sample
  output logic signed [WAVE_WIDTH_P-1:0] osc_triangle
);

  //////////////////////////////////////////////////////////////////////
  // Derived wave constants
  //////////////////////////////////////////////////////////////////////

  // Prime frequency period in system clocks
  // e.g. 200 MHz over 1 MHz gives 200
  localparam int PERIOD_IN_SYS_CLKS_C = SYS_CLK_FREQUENCY_P / PRIME_FREQUENCY_P;

  // One ramp takes half the period
  localparam int HALF_PERIOD_C = PERIOD_IN_SYS_CLKS_C / 2;

  // Step size, full scale spread over one half period
  localparam int WAVE_AMPLITUDE_INC_C = (2**WAVE_WIDTH_P - 1) / HALF_PERIOD_C;

  // Peak, the bottom plus one half period of steps
  // Lands at or just below the top of the signed range
  localparam logic signed [WAVE_WIDTH_P-1:0] WAVE_AMPLITUDE_MAX_C =
    WAVE_WIDTH_P'(-(2**(WAVE_WIDTH_P-1)) + WAVE_AMPLITUDE_INC_C * HALF_PERIOD_C);

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////////////////////////

  // Enable strobe, counter to FSM
  logic clock_enable;

  // Step, direction and limit flags, FSM to accumulator
  osc_ramp_if #(
    .WAVE_WIDTH_P ( WAVE_WIDTH_P )
  ) ramp_if ();

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  // Period counter
  clock_enable #(
    .COUNTER_WIDTH_P  ( COUNTER_WIDTH_P )
  ) clock_enable_i0 (
    .clk              ( clk             ),
    .rst_n            ( rst_n           ),
    .cr_enable_period ( cr_clock_enable ),
    .enable           ( clock_enable    )
  );

  // Rise/fall steering
  osc_triangle_fsm osc_triangle_fsm_i0 (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .clock_enable ( clock_enable ),
    .ramp         ( ramp_if.fsm  )
  );

  // Amplitude register, feeds the output port directly
  osc_amplitude_acc #(
    .WAVE_WIDTH_P         ( WAVE_WIDTH_P         ),
    .WAVE_AMPLITUDE_INC_P ( WAVE_AMPLITUDE_INC_C ),
    .WAVE_AMPLITUDE_MAX_P ( WAVE_AMPLITUDE_MAX_C )
  ) osc_amplitude_acc_i0 (
    .clk       ( clk          ),
    .rst_n     ( rst_n        ),
    .ramp      ( ramp_if.acc  ),
    .amplitude ( osc_triangle )
  );

endmodule

`default_nettype wire

//--- tb/tb_osc_triangle_top.sv
`timescale 1ns/1ps

module tb_osc_triangle_top;

  ////////////////////////////////////////////////////////////////////////
  // Test configuration
  ////////////////////////////////////////////////////////////////////////

  // 200 over 20 gives a period of 10 and a half period of 5
  localparam int SYS_CLK_FREQUENCY_C = 200;
  localparam int PRIME_FREQUENCY_C   = 20;
  localparam int WAVE_WIDTH_C        = 8;
  localparam int COUNTER_WIDTH_C     = $clog2(SYS_CLK_FREQUENCY_C);

  // Expected wave shape at width 8
  // Full scale 255 over 5 steps gives 51
  // Five steps up from -128 land on 127
  localparam int STEP_C = 51;
  localparam int PEAK_C = 127;
  localparam int MIN_C  = -128;

  // Well above the longest table period of 12
  localparam int TIMEOUT_CYCLES_C = 100;
  localparam int NUM_ROWS_C       = 5;

  ////////////////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////////////////

  logic                                  clk;
  logic                                  rst_n;
  logic        [COUNTER_WIDTH_C-1:0]     cr_clock_enable;
  logic signed [WAVE_WIDTH_C-1:0]        osc_triangle;

  osc_triangle_top #(
    .SYS_CLK_FREQUENCY_P ( SYS_CLK_FREQUENCY_C ),
    .PRIME_FREQUENCY_P   ( PRIME_FREQUENCY_C   ),
    .WAVE_WIDTH_P        ( WAVE_WIDTH_C        ),
    .COUNTER_WIDTH_P     ( COUNTER_WIDTH_C     )
  ) i_dut (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .cr_clock_enable ( cr_clock_enable ),
    .osc_triangle    ( osc_triangle    )
  );

  // 4 ns period
  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////

  // Period per row
  // Row 3 gets a random period at run time
  int period_tab  [NUM_ROWS_C] = '{1, 3, 7, 0, 2};
  // Output changes observed per row
  int changes_tab [NUM_ROWS_C] = '{12, 7, 6, 8, 10};

  int unsigned lcg_state = 32'hea38_0da6;

  // Reference triangle state
  int model_amp;
  bit model_rising;

  // Linear congruential generator with the usual 32-bit constants
  function int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////

  // Compare and stop on the first mismatch
  task automatic check_value(input string name, input int observed, input int expected);
    if (observed != expected) begin
      $display("CHECK FAILED at %0t ns: %s observed %0d expected %0d",
               $time, name, observed, expected);
      $display("Regression failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // One step of the reference triangle
  // Turns happen on the step that leaves a limit
  task automatic model_advance();
    if (model_rising) begin
      if (model_amp == PEAK_C) begin
        model_rising = 1'b0;
        model_amp    = model_amp - STEP_C;
      end else begin
        model_amp = model_amp + STEP_C;
      end
    end else begin
      if (model_amp == MIN_C) begin
        model_rising = 1'b1;
        model_amp    = model_amp + STEP_C;
      end else begin
        model_amp = model_amp - STEP_C;
      end
    end
  endtask

  // Sample once per cycle 1 ns after the edge until the output moves
  // Counts the cycles since the last sample point
  task automatic wait_for_change(input int prev, output int new_value, output int cycles);
    bit changed;
    changed = 1'b0;
    cycles  = 0;
    while (!changed) begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
      if (int'(osc_triangle) != prev) begin
        changed   = 1'b1;
        new_value = int'(osc_triangle);
      end else if (cycles >= TIMEOUT_CYCLES_C) begin
        $display("Timeout at %0t ns: osc_triangle never changed within %0d cycles",
                 $time, TIMEOUT_CYCLES_C);
        $display("Regression failed");
        $fatal(1, "no output change");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    int prev;
    int new_value;
    int cycles;
    int exp_interval;

    // Random period in 2..12
    period_tab[3] = 2 + int'((lcg_next() >> 16) % 11);

    rst_n           = 1'b0;
    cr_clock_enable = COUNTER_WIDTH_C'(period_tab[0]);

    // Reset for two cycles and release just after the edge
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Wave must start at the bottom
    check_value("osc_triangle after reset", int'(osc_triangle), MIN_C);
    prev         = int'(osc_triangle);
    model_amp    = MIN_C;
    model_rising = 1'b1;

    for (int row = 0; row < NUM_ROWS_C; row++) begin
      // Still 1 ns after an edge here so the period can change safely
      cr_clock_enable = COUNTER_WIDTH_C'(period_tab[row]);
      exp_interval    = (period_tab[row] < 2) ? 1 : period_tab[row];

      for (int chg = 0; chg < changes_tab[row]; chg++) begin
        wait_for_change(prev, new_value, cycles);
        model_advance();

        // Every change is one full step with no repeat at a corner and no overshoot
        check_value("osc_triangle step size",
                    (new_value > prev) ? new_value - prev : prev - new_value, STEP_C);
        if (prev == PEAK_C) begin
          check_value("osc_triangle falls after peak", int'(new_value < prev), 1);
        end
        if (prev == MIN_C) begin
          check_value("osc_triangle rises after minimum", int'(new_value > prev), 1);
        end

        check_value("osc_triangle", new_value, model_amp);

        // First change of a row may come from the old period
        if (chg > 0) begin
          check_value("osc_triangle change interval", cycles, exp_interval);
        end

        prev = new_value;
      end
    end

    $display("Regression passed");
    $finish;
  end

endmodule

//--- osc_triangle_top.f
hw/osc_pkg.sv
hw/osc_ramp_if.sv
hw/clock_enable.sv
hw/osc_triangle_fsm.sv
hw/osc_amplitude_acc.sv
hw/osc_triangle_top.sv
tb/tb_osc_triangle_top.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_osc_triangle_top
FILELIST   ?= osc_triangle_top.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the printed output only
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
